// File: Bender.yml
package:
  name: doe

sources:
  - design/doe_pkg.sv
  - design/kv_pkg.sv
  - design/kv_write_if.sv
  - design/doe_cipher_if.sv
  - design/doe_apb_regs.sv
  - design/kv_write_rule_check.sv
  - design/doe_cipher_core.sv
  - design/key_vault.sv
  - design/doe_fsm.sv
  - design/doe_top.sv
  - target: test
    files:
      - test/doe_fsm_sva.sv
      - test/doe_top_tb.sv

// File: design/doe_apb_regs.sv
// APB register block holding the DOE command, flow status and lock/zeroize control
`timescale 1ns/1ps

module doe_apb_regs (
    input  logic              clk,
    input  logic              rst_b,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [3:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output doe_pkg::doe_cmd_e cmd,
    output logic [1:0]        dest_sel,
    output logic              ocp_lock_en,
    output logic              zeroize,
    input  logic              flow_done,
    input  logic              flow_error,
    input  logic              flow_in_progress,
    input  logic              lock_uds_flow,
    input  logic              lock_fe_flow
);

    logic wr_access;
    logic done_q;
    logic error_q;

    // no wait states on this bus
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_access = psel & penable & pwrite;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cmd         <= doe_pkg::DOE_NONE;
            dest_sel    <= '0;
            ocp_lock_en <= 1'b0;
            zeroize     <= 1'b0;
            done_q      <= 1'b0;
            error_q     <= 1'b0;
        end else begin
            // zeroize is a single pulse per CTRL write with bit 0 set
            zeroize <= wr_access && (paddr == doe_pkg::REG_CTRL) && pwdata[0];
            if (wr_access && (paddr == doe_pkg::REG_CTRL)) begin
                ocp_lock_en <= pwdata[1];
            end
            if (wr_access && (paddr == doe_pkg::REG_CMD)) begin
                cmd      <= doe_pkg::doe_cmd_e'(pwdata[1:0]);
                dest_sel <= pwdata[5:4];
                done_q   <= 1'b0;
                error_q  <= 1'b0;
            end else begin
                if (flow_done || zeroize) begin
                    cmd <= doe_pkg::DOE_NONE;
                end
                // status bits stay set until the next command
                done_q  <= done_q | flow_done;
                error_q <= error_q | flow_error;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                doe_pkg::REG_CMD:    prdata = {26'd0, dest_sel, 2'b00, cmd};
                doe_pkg::REG_STATUS: prdata = {27'd0, lock_fe_flow, lock_uds_flow,
                                               error_q, done_q, flow_in_progress};
                doe_pkg::REG_CTRL:   prdata = {30'd0, ocp_lock_en, 1'b0};
                default:             prdata = '0;
            endcase
        end
    end

endmodule

// File: design/doe_cipher_core.sv
// chained rotate-and-xor unmasking core with init/next handshake
`timescale 1ns/1ps

module doe_cipher_core (
    input  logic       clk,
    input  logic       rst_b,
    doe_cipher_if.core cipher
);

    logic [3:0]                  cnt;
    logic                        rounds_on;
    logic [doe_pkg::BLOCK_W-1:0] work;
    logic [doe_pkg::BLOCK_W-1:0] chain;
    logic [doe_pkg::BLOCK_W-1:0] round_out;

    // one round rotates left by a byte and mixes in the key
    assign round_out = {work[doe_pkg::BLOCK_W-9:0], work[doe_pkg::BLOCK_W-1:doe_pkg::BLOCK_W-8]}
                       ^ doe_pkg::OBF_KEY;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cnt               <= '0;
            rounds_on         <= 1'b0;
            cipher.init_done  <= 1'b0;
            cipher.dest_avail <= 1'b0;
        end else if (cipher.init) begin
            cnt               <= 4'(doe_pkg::INIT_CYCLES);
            rounds_on         <= 1'b0;
            cipher.init_done  <= 1'b0;
            cipher.dest_avail <= 1'b0;
        end else if (cipher.next) begin
            cnt               <= 4'(doe_pkg::CIPHER_ROUNDS);
            rounds_on         <= 1'b1;
            cipher.init_done  <= 1'b0;
            cipher.dest_avail <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == 4'd1) begin
                cipher.init_done  <= 1'b1;
                cipher.dest_avail <= rounds_on;
            end
        end
    end

    // each loaded block is xored with the previous result before its rounds
    always_ff @(posedge clk) begin
        if (cipher.init) begin
            chain <= '0;
        end else if (cipher.src_write_en) begin
            work <= cipher.src_data ^ chain;
        end else if (rounds_on && (cnt != '0)) begin
            work <= round_out;
            if (cnt == 4'd1) chain <= round_out;
        end
    end

    assign cipher.dest_data = work;

endmodule

// File: design/doe_cipher_if.sv
// init/next handshake between the DOE controller and the unmasking core
`timescale 1ns/1ps

interface doe_cipher_if;

    logic                         init;
    logic                         src_write_en;
    logic [doe_pkg::BLOCK_W-1:0]  src_data;
    logic                         next;
    logic                         init_done;
    logic                         dest_avail;
    logic [doe_pkg::BLOCK_W-1:0]  dest_data;

    modport ctrl (
        output init, output src_write_en, output src_data, output next,
        input  init_done, input dest_avail, input dest_data
    );
    modport core (
        input  init, input src_write_en, input src_data, input next,
        output init_done, output dest_avail, output dest_data
    );

endinterface

// File: design/doe_fsm.sv
// DOE flow controller sequencing unmasking blocks into checked vault writes
`timescale 1ns/1ps

module doe_fsm (
    input  logic                clk,
    input  logic                rst_b,
    input  logic                hard_rst_b,
    input  logic [127:0]        obf_uds_seed,
    input  logic [63:0]         obf_field_entropy,
    input  doe_pkg::doe_cmd_e   cmd,
    input  logic [1:0]          dest_sel,
    input  logic                ocp_lock_en,
    input  logic                zeroize,
    doe_cipher_if.ctrl          cipher,
    kv_write_if.ctrl            kv_wr,
    output logic                flow_done,
    output logic                flow_error,
    output logic                flow_in_progress,
    output logic                lock_uds_flow,
    output logic                lock_fe_flow
);

    doe_pkg::doe_state_e state;
    doe_pkg::doe_state_e state_nxt;

    logic running_uds;
    logic running_fe;
    logic start;
    logic locked_cmd;
    logic zeroize_hold;
    logic block_done;
    logic write_en;
    logic write_last;

    logic [$clog2(doe_pkg::UDS_BLOCKS)-1:0] block_offset;
    logic [kv_pkg::KV_OFFSET_W-1:0]         dword_offset;
    logic [kv_pkg::KV_ENTRY_W-1:0]          dest_entry;

    kv_pkg::kv_write_metrics_t write_metrics;
    logic                      kv_write_allow;

    assign running_uds      = (cmd == doe_pkg::DOE_UDS);
    assign running_fe       = (cmd == doe_pkg::DOE_FE);
    assign flow_in_progress = running_uds | running_fe;
    assign start            = (running_uds & ~lock_uds_flow) | (running_fe & ~lock_fe_flow);
    assign locked_cmd       = (running_uds & lock_uds_flow) | (running_fe & lock_fe_flow);
    assign block_done       = running_uds ? (block_offset == doe_pkg::UDS_BLOCKS - 1) :
                                            (block_offset == doe_pkg::FE_BLOCKS - 1);

    // a block is finished once its lower dword has gone out
    assign write_last = kv_write_allow & dword_offset[0];

    // widen the zeroize pulse so the controller sits in IDLE until a new command
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            zeroize_hold <= 1'b0;
        end else if (zeroize) begin
            zeroize_hold <= 1'b1;
        end else if (flow_in_progress) begin
            zeroize_hold <= 1'b0;
        end
    end

    always_comb begin
        state_nxt           = state;
        cipher.init         = 1'b0;
        cipher.next         = 1'b0;
        cipher.src_write_en = 1'b0;
        write_en            = 1'b0;
        flow_done           = 1'b0;
        flow_error          = 1'b0;
        case (state)
            doe_pkg::DOE_IDLE: begin
                // a locked command finishes at once without touching the vault
                flow_done = locked_cmd;
                if (start) state_nxt = doe_pkg::DOE_INIT;
            end
            doe_pkg::DOE_INIT: begin
                cipher.init = 1'b1;
                state_nxt   = doe_pkg::DOE_WAIT;
            end
            doe_pkg::DOE_BLOCK: begin
                cipher.src_write_en = 1'b1;
                state_nxt           = doe_pkg::DOE_NEXT;
            end
            doe_pkg::DOE_NEXT: begin
                cipher.next = 1'b1;
                state_nxt   = doe_pkg::DOE_WAIT;
            end
            doe_pkg::DOE_WAIT: begin
                if (cipher.init_done && cipher.dest_avail) state_nxt = doe_pkg::DOE_WRITE;
                else if (cipher.init_done) state_nxt = doe_pkg::DOE_BLOCK;
            end
            doe_pkg::DOE_WRITE: begin
                // a denied write stalls here until zeroize
                write_en   = kv_write_allow;
                flow_error = ~kv_write_allow;
                if (write_last && block_done) state_nxt = doe_pkg::DOE_DONE;
                else if (write_last) state_nxt = doe_pkg::DOE_BLOCK;
            end
            doe_pkg::DOE_DONE: begin
                flow_done = 1'b1;
                state_nxt = doe_pkg::DOE_IDLE;
            end
            default: state_nxt = doe_pkg::DOE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state        <= doe_pkg::DOE_IDLE;
            block_offset <= '0;
            dword_offset <= '0;
            dest_entry   <= '0;
        end else if (zeroize_hold) begin
            state        <= doe_pkg::DOE_IDLE;
            block_offset <= '0;
            dword_offset <= '0;
            dest_entry   <= '0;
        end else begin
            state <= state_nxt;
            if ((state == doe_pkg::DOE_IDLE) && start) begin
                dest_entry <= dest_sel;
            end
            if (state == doe_pkg::DOE_DONE) begin
                block_offset <= '0;
                dword_offset <= '0;
            end else begin
                if (write_en) dword_offset <= dword_offset + 1'b1;
                if ((state == doe_pkg::DOE_WRITE) && write_last && !block_done) begin
                    block_offset <= block_offset + 1'b1;
                end
            end
        end
    end

    // block 0 sits in the low bits of the seed
    assign cipher.src_data = running_uds ?
                             obf_uds_seed[block_offset*doe_pkg::BLOCK_W +: doe_pkg::BLOCK_W] :
                             obf_field_entropy;

    assign write_metrics.entry     = dest_entry;
    assign write_metrics.lock_mode = ocp_lock_en;

    // decision settles before the first WAIT since the entry latches leaving IDLE
    kv_write_rule_check u_rule_check (
        .clk           (clk),
        .rst_b         (rst_b),
        .write_metrics (write_metrics),
        .write_allow   (kv_write_allow)
    );

    // the upper half of each result is stored first
    assign kv_wr.write_en = write_en;
    assign kv_wr.entry    = dest_entry;
    assign kv_wr.offset   = dword_offset;
    assign kv_wr.data     = !write_en ? 32'd0 :
                            dword_offset[0] ? cipher.dest_data[31:0] :
                                              cipher.dest_data[doe_pkg::BLOCK_W-1:32];

    // flow locks survive a warm reset
    always_ff @(posedge clk or negedge hard_rst_b) begin
        if (!hard_rst_b) begin
            lock_uds_flow <= 1'b0;
            lock_fe_flow  <= 1'b0;
        end else begin
            lock_uds_flow <= lock_uds_flow | (running_uds & flow_done);
            lock_fe_flow  <= lock_fe_flow | (running_fe & flow_done);
        end
    end

endmodule

// File: design/doe_pkg.sv
// DOE command, controller state, block sizing and register map definitions
package doe_pkg;

    typedef enum logic [1:0] {
        DOE_NONE = 2'd0,
        DOE_UDS  = 2'd1,
        DOE_FE   = 2'd2
    } doe_cmd_e;

    typedef enum logic [2:0] {
        DOE_IDLE  = 3'b000,
        DOE_INIT  = 3'b001,
        DOE_BLOCK = 3'b011,
        DOE_NEXT  = 3'b010,
        DOE_WAIT  = 3'b110,
        DOE_WRITE = 3'b100,
        DOE_DONE  = 3'b101
    } doe_state_e;

    localparam int BLOCK_W       = 64;
    localparam int UDS_BLOCKS    = 2;
    localparam int FE_BLOCKS     = 1;
    localparam int CIPHER_ROUNDS = 4;
    localparam int INIT_CYCLES   = 2;

    // fixed unmasking key shared by every flow
    localparam logic [BLOCK_W-1:0] OBF_KEY = 64'h5a3c_96e1_0f87_c24b;

    localparam logic [3:0] REG_CMD    = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;

endpackage

// File: design/doe_top.sv
// DOE top level joining the APB registers, flow controller, unmasking core and key vault
`timescale 1ns/1ps

module doe_top (
    input  logic                           clk,
    input  logic                           rst_b,
    input  logic                           hard_rst_b,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [3:0]                     paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic [127:0]                   obf_uds_seed,
    input  logic [63:0]                    obf_field_entropy,
    input  logic [kv_pkg::KV_ENTRY_W-1:0]  kv_rd_entry,
    input  logic [kv_pkg::KV_OFFSET_W-1:0] kv_rd_offset,
    output logic [31:0]                    kv_rd_data
);

    doe_pkg::doe_cmd_e cmd;
    logic [1:0]        dest_sel;
    logic              ocp_lock_en;
    logic              zeroize;
    logic              flow_done;
    logic              flow_error;
    logic              flow_in_progress;
    logic              lock_uds_flow;
    logic              lock_fe_flow;

    kv_write_if   kv_wr ();
    doe_cipher_if cipher ();

    doe_apb_regs u_regs (
        .clk              (clk),
        .rst_b            (rst_b),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .cmd              (cmd),
        .dest_sel         (dest_sel),
        .ocp_lock_en      (ocp_lock_en),
        .zeroize          (zeroize),
        .flow_done        (flow_done),
        .flow_error       (flow_error),
        .flow_in_progress (flow_in_progress),
        .lock_uds_flow    (lock_uds_flow),
        .lock_fe_flow     (lock_fe_flow)
    );

    doe_fsm u_fsm (
        .clk               (clk),
        .rst_b             (rst_b),
        .hard_rst_b        (hard_rst_b),
        .obf_uds_seed      (obf_uds_seed),
        .obf_field_entropy (obf_field_entropy),
        .cmd               (cmd),
        .dest_sel          (dest_sel),
        .ocp_lock_en       (ocp_lock_en),
        .zeroize           (zeroize),
        .cipher            (cipher.ctrl),
        .kv_wr             (kv_wr.ctrl),
        .flow_done         (flow_done),
        .flow_error        (flow_error),
        .flow_in_progress  (flow_in_progress),
        .lock_uds_flow     (lock_uds_flow),
        .lock_fe_flow      (lock_fe_flow)
    );

    doe_cipher_core u_core (
        .clk    (clk),
        .rst_b  (rst_b),
        .cipher (cipher.core)
    );

    key_vault u_vault (
        .clk       (clk),
        .rst_b     (rst_b),
        .kv_wr     (kv_wr.vault),
        .rd_entry  (kv_rd_entry),
        .rd_offset (kv_rd_offset),
        .rd_data   (kv_rd_data)
    );

endmodule

// File: design/key_vault.sv
// four-entry key vault of four dwords each, one write port and a combinational read
`timescale 1ns/1ps

module key_vault (
    input  logic                           clk,
    input  logic                           rst_b,
    kv_write_if.vault                      kv_wr,
    input  logic [kv_pkg::KV_ENTRY_W-1:0]  rd_entry,
    input  logic [kv_pkg::KV_OFFSET_W-1:0] rd_offset,
    output logic [31:0]                    rd_data
);

    logic [31:0] mem [kv_pkg::KV_ENTRIES*kv_pkg::KV_DWORDS];

    // secrets must not survive a reset, so the whole array clears
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < kv_pkg::KV_ENTRIES*kv_pkg::KV_DWORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (kv_wr.write_en) begin
            mem[{kv_wr.entry, kv_wr.offset}] <= kv_wr.data;
        end
    end

    assign rd_data = mem[{rd_entry, rd_offset}];

endmodule

// File: design/kv_pkg.sv
// key vault geometry and write-rule definitions
package kv_pkg;

    localparam int KV_ENTRIES  = 4;
    localparam int KV_DWORDS   = 4;
    localparam int KV_ENTRY_W  = 2;
    localparam int KV_OFFSET_W = 2;

    // what the rule check needs to know about a pending write
    typedef struct packed {
        logic                  lock_mode;
        logic [KV_ENTRY_W-1:0] entry;
    } kv_write_metrics_t;

    // entry 0 is never a DOE target
    localparam logic [KV_ENTRY_W-1:0] KV_RESERVED_ENTRY = 2'd0;

    // entries from here up are only writable in lock mode
    localparam logic [KV_ENTRY_W-1:0] KV_LOCKED_MIN_ENTRY = 2'd2;

endpackage

// File: design/kv_write_if.sv
// single dword write path from the DOE controller into the key vault
`timescale 1ns/1ps

interface kv_write_if;

    logic                           write_en;
    logic [kv_pkg::KV_ENTRY_W-1:0]  entry;
    logic [kv_pkg::KV_OFFSET_W-1:0] offset;
    logic [31:0]                    data;

    modport ctrl  (output write_en, output entry, output offset, output data);
    modport vault (input  write_en, input  entry, input  offset, input  data);

endinterface

// File: design/kv_write_rule_check.sv
// registered allow/deny decision for DOE writes into the key vault
`timescale 1ns/1ps

module kv_write_rule_check (
    input  logic                      clk,
    input  logic                      rst_b,
    input  kv_pkg::kv_write_metrics_t write_metrics,
    output logic                      write_allow
);

    logic reserved_hit;
    logic lock_needed;

    assign reserved_hit = (write_metrics.entry == kv_pkg::KV_RESERVED_ENTRY);
    assign lock_needed  = (write_metrics.entry >= kv_pkg::KV_LOCKED_MIN_ENTRY);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            write_allow <= 1'b0;
        end else begin
            write_allow <= ~reserved_hit & (~lock_needed | write_metrics.lock_mode);
        end
    end

endmodule

// File: src.f
design/doe_pkg.sv
design/kv_pkg.sv
design/kv_write_if.sv
design/doe_cipher_if.sv
design/doe_apb_regs.sv
design/kv_write_rule_check.sv
design/doe_cipher_core.sv
design/key_vault.sv
design/doe_fsm.sv
design/doe_top.sv
test/doe_fsm_sva.sv
test/doe_top_tb.sv

// File: test/doe_fsm_sva.sv
// concurrent checks on the DOE controller handshake, vault writes and done pulse
`timescale 1ns/1ps

module doe_fsm_sva (
    input logic                clk,
    input logic                rst_b,
    input doe_pkg::doe_state_e state,
    input logic                init,
    input logic                next,
    input logic                write_en,
    input logic                write_allow,
    input logic                flow_done
);

    int unsigned assert_errors = 0;

    // the core gets either an init or a next, never both
    a_init_next_excl: assert property (@(posedge clk) disable iff (!rst_b)
        !(init && next))
        else begin
            assert_errors++;
            $error("init and next are high in the same cycle");
        end

    a_write_allowed: assert property (@(posedge clk) disable iff (!rst_b)
        write_en |-> (write_allow && (state == doe_pkg::DOE_WRITE)))
        else begin
            assert_errors++;
            $error("vault write without write_allow or outside WRITE");
        end

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_b)
        flow_done |=> !flow_done)
        else begin
            assert_errors++;
            $error("flow_done stays high for more than one cycle");
        end

endmodule

// File: test/doe_top_tb.sv
// testbench for the DOE top level covering UDS/FE flows, rule denials, locks and zeroize
`timescale 1ns/1ps

module doe_top_tb;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int FLOW_LIMIT      = 120;

    logic                           clk = 1'b0;
    logic                           rst_b;
    logic                           hard_rst_b;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [3:0]                     paddr;
    logic [31:0]                    pwdata;
    logic [31:0]                    prdata;
    logic                           pready;
    logic                           pslverr;
    logic [127:0]                   uds_seed;
    logic [63:0]                    fe_seed;
    logic [kv_pkg::KV_ENTRY_W-1:0]  kv_rd_entry;
    logic [kv_pkg::KV_OFFSET_W-1:0] kv_rd_offset;
    logic [31:0]                    kv_rd_data;

    integer      seed;
    int unsigned check_count = 0;
    int unsigned error_count = 0;

    // request to the compare process
    event                          compare_req;
    logic                          cmp_busy = 1'b0;
    string                         cmp_name;
    logic [kv_pkg::KV_ENTRY_W-1:0] cmp_entry;
    logic [127:0]                  cmp_expected;

    always #20 clk = ~clk;

    doe_top dut (
        .clk               (clk),
        .rst_b             (rst_b),
        .hard_rst_b        (hard_rst_b),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .obf_uds_seed      (uds_seed),
        .obf_field_entropy (fe_seed),
        .kv_rd_entry       (kv_rd_entry),
        .kv_rd_offset      (kv_rd_offset),
        .kv_rd_data        (kv_rd_data)
    );

    bind doe_fsm doe_fsm_sva u_sva (
        .clk         (clk),
        .rst_b       (rst_b),
        .state       (state),
        .init        (cipher.init),
        .next        (cipher.next),
        .write_en    (kv_wr.write_en),
        .write_allow (kv_write_allow),
        .flow_done   (flow_done)
    );

    // dword k of the vault entry sits in bits [32k +: 32], upper result half first
    function automatic logic [127:0] expected_dwords(input doe_pkg::doe_cmd_e cmd,
                                                     input logic [127:0] uds,
                                                     input logic [63:0] fe);
        logic [127:0] dwords;
        logic [63:0]  chain;
        logic [63:0]  w;
        int           nblk;
        dwords = '0;
        chain  = '0;
        nblk   = (cmd == doe_pkg::DOE_UDS) ? doe_pkg::UDS_BLOCKS : doe_pkg::FE_BLOCKS;
        for (int b = 0; b < nblk; b++) begin
            w = ((cmd == doe_pkg::DOE_UDS) ? uds[b*64 +: 64] : fe) ^ chain;
            for (int r = 0; r < doe_pkg::CIPHER_ROUNDS; r++) begin
                w = {w[55:0], w[63:56]} ^ doe_pkg::OBF_KEY;
            end
            chain = w;
            dwords[(2*b)*32 +: 32]   = w[63:32];
            dwords[(2*b+1)*32 +: 32] = w[31:0];
        end
        return dwords;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // every access completes in its access phase with no error response
    task automatic check_apb_response(input string name);
        check_value($sformatf("%s pready", name), 32'd1, {31'd0, pready});
        check_value($sformatf("%s pslverr", name), 32'd0, {31'd0, pslverr});
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        check_apb_response("apb write");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // read data is combinational during the access phase
        @(negedge clk);
        data = prdata;
        check_apb_response("apb read");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic start_flow(input doe_pkg::doe_cmd_e cmd,
                              input logic [kv_pkg::KV_ENTRY_W-1:0] entry);
        apb_write(doe_pkg::REG_CMD, {26'd0, entry, 2'b00, cmd});
    endtask

    // poll STATUS until done or error shows up
    task automatic wait_flow_end(input string name, input int max_cycles,
                                 output logic [31:0] status);
        int waited;
        waited = 0;
        apb_read(doe_pkg::REG_STATUS, status);
        while (!status[1] && !status[2] && (waited < max_cycles)) begin
            apb_read(doe_pkg::REG_STATUS, status);
            waited += 3;
        end
        if (!status[1] && !status[2]) begin
            error_count++;
            $display("ERROR: %s: STATUS shows neither done nor error after %0d cycles",
                     name, waited);
        end
    endtask

    task automatic pulse_reset(input logic warm, input logic hard);
        @(posedge clk);
        #2;
        if (warm) rst_b = 1'b0;
        if (hard) hard_rst_b = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_b      = 1'b1;
        hard_rst_b = 1'b1;
    endtask

    task automatic compare_entry(input string name, input logic [kv_pkg::KV_ENTRY_W-1:0] entry,
                                 input logic [127:0] expected);
        cmp_name     = name;
        cmp_entry    = entry;
        cmp_expected = expected;
        cmp_busy     = 1'b1;
        -> compare_req;
        wait (!cmp_busy);
    endtask

    // reads one vault entry through the read port and checks every dword
    initial begin : compare_proc
        forever begin
            @(compare_req);
            for (int k = 0; k < kv_pkg::KV_DWORDS; k++) begin
                @(posedge clk);
                #2;
                kv_rd_entry  = cmp_entry;
                kv_rd_offset = 2'(k);
                @(negedge clk);
                check_value($sformatf("%s dword %0d", cmp_name, k),
                            cmp_expected[k*32 +: 32], kv_rd_data);
            end
            cmp_busy = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("ERROR: simulation timed out after %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0]       status;
        doe_pkg::doe_cmd_e cmd;
        logic [1:0]        entry;
        int unsigned       total_errors;
        seed         = 32'h153;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        kv_rd_entry  = '0;
        kv_rd_offset = '0;
        uds_seed     = {$random(seed), $random(seed), $random(seed), $random(seed)};
        fe_seed      = {$random(seed), $random(seed)};
        rst_b        = 1'b0;
        hard_rst_b   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_b      = 1'b1;
        hard_rst_b = 1'b1;

        // 1: UDS into entry 1 without lock mode
        start_flow(doe_pkg::DOE_UDS, 2'd1);
        wait_flow_end("uds_entry1", FLOW_LIMIT, status);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("uds_entry1 status", 32'h0a, status);
        compare_entry("uds_entry1", 2'd1, expected_dwords(doe_pkg::DOE_UDS, uds_seed, fe_seed));

        // 2: FE into a lock-mode entry
        apb_write(doe_pkg::REG_CTRL, 32'h2);
        start_flow(doe_pkg::DOE_FE, 2'd2);
        wait_flow_end("fe_entry2", FLOW_LIMIT, status);
        check_value("fe_entry2 status", 32'h1a, status);
        compare_entry("fe_entry2", 2'd2, expected_dwords(doe_pkg::DOE_FE, uds_seed, fe_seed));

        // 3: a second UDS is locked out and finishes at once
        start_flow(doe_pkg::DOE_UDS, 2'd3);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("uds_relock status", 32'h1a, status);
        compare_entry("uds_relock", 2'd3, 128'd0);
        pulse_reset(1'b1, 1'b0);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("warm reset status", 32'h18, status);
        pulse_reset(1'b0, 1'b1);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("hard reset status", 32'h00, status);

        // 4: entry 0 is denied and the flow stalls until zeroize
        start_flow(doe_pkg::DOE_FE, 2'd0);
        wait_flow_end("fe_entry0", FLOW_LIMIT, status);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("fe_entry0 status", 32'h05, status);
        compare_entry("fe_entry0", 2'd0, 128'd0);
        apb_write(doe_pkg::REG_CTRL, 32'h1);
        repeat (3) @(posedge clk);
        apb_read(doe_pkg::REG_STATUS, status);
        check_value("zeroize in progress", 32'd0, {31'd0, status[0]});
        start_flow(doe_pkg::DOE_FE, 2'd1);
        wait_flow_end("fe_entry1", FLOW_LIMIT, status);
        check_value("fe_entry1 status", 32'h12, status);
        compare_entry("fe_entry1", 2'd1, expected_dwords(doe_pkg::DOE_FE, uds_seed, fe_seed));

        // 5: random seeds and entries, each round from a fresh reset
        for (int r = 0; r < 3; r++) begin
            pulse_reset(1'b1, 1'b1);
            uds_seed = {$random(seed), $random(seed), $random(seed), $random(seed)};
            fe_seed  = {$random(seed), $random(seed)};
            cmd      = ($random(seed) & 1) ? doe_pkg::DOE_UDS : doe_pkg::DOE_FE;
            entry    = 2'(1 + ($unsigned($random(seed)) % 3));
            apb_write(doe_pkg::REG_CTRL, 32'h2);
            start_flow(cmd, entry);
            wait_flow_end($sformatf("random round %0d", r), FLOW_LIMIT, status);
            check_value($sformatf("random round %0d status", r),
                        32'h2 | ((cmd == doe_pkg::DOE_UDS) ? 32'h8 : 32'h10), status);
            compare_entry($sformatf("random round %0d", r), entry,
                          expected_dwords(cmd, uds_seed, fe_seed));
        end

        total_errors = error_count + dut.u_fsm.u_sva.assert_errors;
        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 check_count, error_count, dut.u_fsm.u_sva.assert_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
